//--- filelist.f
logic/lock_pkg.sv
logic/key_decoder.sv
logic/code_entry.sv
logic/tone_gen.sv
logic/tone_arbiter.sv
logic/keypad_lock.sv
sim/tb_keypad_lock.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the keypad lock testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_keypad_lock \
    -o tb_keypad_lock

./obj_dir/tb_keypad_lock > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "\*\*\* PASSED \*\*\*" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- sim/tb_keypad_lock.sv
`timescale 1ns/1ps

module tb_keypad_lock;

    localparam int CLICK_HALF     = 2;
    localparam int CLICK_LEN      = 20;
    localparam int OK_HALF        = 3;
    localparam int OK_LEN         = 60;
    localparam int FAIL_HALF      = 4;
    localparam int FAIL_LEN       = 40;
    localparam int FAIL_GAP_START = 10;
    localparam int FAIL_GAP_END   = 20;
    localparam logic [lock_pkg::DISP_W-1:0] PASSCODE = 12'h246;

    localparam int PRESS_CYC = 6;  // 3 held plus 3 released
    // generous bound on the whole run
    localparam int WATCHDOG_CYC = 16 + 100 * PRESS_CYC + 4 * CLICK_LEN + 4 * OK_LEN
                                  + 4 * FAIL_LEN + 500;

    // keypad line per key code, digits 0..9 then Enter, Clear, Reset
    localparam int KEY_LINE [13] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13, 0, 12, 8};

    logic                          clk;
    logic                          arst_n;
    logic [15:0]                   onehot;
    logic [lock_pkg::DISP_W-1:0]   display;
    logic [lock_pkg::TRIES_W-1:0]  tries;
    logic                          unlocked;
    logic                          locked_out;
    logic                          buzzer;

    integer                        seed = 32'h31f;
    int                            buzz_rise;  // first cycle buzzer seen high in a press, 0 if none
    int                            highs;
    int                            toggles;
    logic [lock_pkg::TRIES_W-1:0]  exp_tries;

    keypad_lock #(
        .PASSCODE       (PASSCODE),
        .CLICK_HALF     (CLICK_HALF),
        .CLICK_LEN      (CLICK_LEN),
        .OK_HALF        (OK_HALF),
        .OK_LEN         (OK_LEN),
        .FAIL_HALF      (FAIL_HALF),
        .FAIL_LEN       (FAIL_LEN),
        .FAIL_GAP_START (FAIL_GAP_START),
        .FAIL_GAP_END   (FAIL_GAP_END)
    ) u_keypad_lock (
        .clk        (clk),
        .arst_n     (arst_n),
        .onehot     (onehot),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked_out (locked_out),
        .buzzer     (buzzer)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_display(input logic [lock_pkg::DISP_W-1:0] exp);
        if (display !== exp) begin
            stop_on_error($sformatf("FAILED display: got %h, expected %h", display, exp));
        end
    endtask

    task automatic check_tries(input logic [lock_pkg::TRIES_W-1:0] exp);
        if (tries !== exp) begin
            stop_on_error($sformatf("FAILED tries: got %h, expected %h", tries, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, act, exp));
        end
    endtask

    // drive a keypad word, release it, note when the buzzer first goes high
    task automatic press_word(input logic [15:0] word);
        @(posedge clk);
        onehot <= word;
        buzz_rise = 0;
        for (int i = 1; i <= PRESS_CYC; i++) begin
            @(posedge clk);
            if (i == 3) begin
                onehot <= '0;
            end
            @(negedge clk);
            if (buzzer && buzz_rise == 0) begin
                buzz_rise = i;
            end
        end
    endtask

    task automatic press_key(input logic [lock_pkg::KEY_W-1:0] code);
        press_word(16'h1 << KEY_LINE[code]);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // count high samples and level changes of the buzzer
    task automatic watch_buzzer(input int n);
        logic prev;
        highs   = 0;
        toggles = 0;
        prev    = buzzer;
        repeat (n) begin
            @(negedge clk);
            if (buzzer) begin
                highs++;
            end
            if (buzzer !== prev) begin
                toggles++;
            end
            prev = buzzer;
        end
    endtask

    task automatic enter_code(input logic [lock_pkg::DISP_W-1:0] code);
        press_key(code[11:8]);
        press_key(code[7:4]);
        press_key(code[3:0]);
        press_key(lock_pkg::KEY_ENTER);
    endtask

    task automatic pick_wrong_code(output logic [lock_pkg::DISP_W-1:0] code);
        code[11:8] = 4'($unsigned($random(seed)) % 10);
        code[7:4]  = 4'($unsigned($random(seed)) % 10);
        code[3:0]  = 4'($unsigned($random(seed)) % 10);
        if (code == PASSCODE) begin
            code[3:0] = (code[3:0] == 4'd9) ? 4'd0 : code[3:0] + 4'd1;
        end
    endtask

    task automatic test_reset_state();
        check_display(lock_pkg::DISP_BLANK);
        check_tries('0);
        check_flag("unlocked", unlocked, 1'b0);
        check_flag("locked_out", locked_out, 1'b0);
        check_flag("buzzer", buzzer, 1'b0);
    endtask

    task automatic test_digit_entry();
        int                          digits [4]   = '{7, 7, 1, 5};
        logic [lock_pkg::DISP_W-1:0] exp_disp [4] = '{12'hFF7, 12'hF77, 12'h771, 12'h771};
        for (int i = 0; i < 4; i++) begin
            press_key(4'(digits[i]));
            check_display(exp_disp[i]);  // fourth digit dropped
            if (buzz_rise == 0 || buzz_rise > 3) begin
                stop_on_error("buzzer did not go high within 3 cycles of a digit key");
            end
            wait_cycles(CLICK_LEN + 3 - PRESS_CYC);
            check_flag("buzzer", buzzer, 1'b0);
        end
        press_key(lock_pkg::KEY_CLEAR);
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
    endtask

    task automatic test_correct_code();
        enter_code(PASSCODE);
        check_display(lock_pkg::DISP_PASS);
        check_flag("unlocked", unlocked, 1'b1);
        watch_buzzer(OK_LEN - 4);  // up to the last success cycle
        if (toggles < (OK_LEN - 8) / OK_HALF) begin
            stop_on_error("buzzer did not toggle through the success tone");
        end
        watch_buzzer(10);
        if (highs != 0) begin
            stop_on_error("buzzer kept sounding after the success tone");
        end
        press_key(4'd1);
        check_display(lock_pkg::DISP_PASS);
        if (buzz_rise != 0) begin
            stop_on_error("a digit clicked while unlocked");
        end
        press_key(lock_pkg::KEY_RESET);
        test_reset_state();
    endtask

    task automatic test_wrong_code();
        logic [lock_pkg::DISP_W-1:0] code;
        pick_wrong_code(code);
        enter_code(code);
        exp_tries = exp_tries + 1'b1;
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
        check_flag("locked_out", locked_out, 1'b0);
        // press ends on failure tone cycle 3 in its first high half
        check_flag("buzzer", buzzer, 1'b1);
        // the next sample is tone cycle PRESS_CYC - 2
        watch_buzzer(FAIL_GAP_START - PRESS_CYC + 2);
        if (highs == 0) begin
            stop_on_error("failure tone silent before its gap");
        end
        watch_buzzer(FAIL_GAP_END - FAIL_GAP_START);
        if (highs != 0) begin
            stop_on_error("failure tone sounded inside its gap");
        end
        watch_buzzer(FAIL_LEN - FAIL_GAP_END);
        if (highs == 0) begin
            stop_on_error("failure tone silent after its gap");
        end
        watch_buzzer(5);
        if (highs != 0) begin
            stop_on_error("buzzer kept sounding after the failure tone");
        end
        // Enter with two digits is ignored
        press_key(4'd3);
        press_key(4'd8);
        press_key(lock_pkg::KEY_ENTER);
        check_display({lock_pkg::BLANK_NIBBLE, 4'd3, 4'd8});
        check_tries(exp_tries);
        check_flag("locked_out", locked_out, 1'b0);
        press_key(lock_pkg::KEY_CLEAR);
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
    endtask

    task automatic test_lockout();
        logic [lock_pkg::DISP_W-1:0] code;
        press_key(lock_pkg::KEY_RESET);
        exp_tries = '0;
        check_tries(exp_tries);
        repeat (lock_pkg::MAX_TRIES) begin
            pick_wrong_code(code);
            enter_code(code);
            exp_tries = exp_tries + 1'b1;
            check_tries(exp_tries);
        end
        check_display(lock_pkg::DISP_LOCKOUT);
        check_tries(lock_pkg::MAX_TRIES);
        check_flag("locked_out", locked_out, 1'b1);
        enter_code(PASSCODE);  // ignored while locked out
        check_display(lock_pkg::DISP_LOCKOUT);
        check_flag("unlocked", unlocked, 1'b0);
        check_flag("locked_out", locked_out, 1'b1);
        press_key(lock_pkg::KEY_RESET);
        exp_tries = '0;
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
        check_flag("locked_out", locked_out, 1'b0);
        enter_code(PASSCODE);
        check_display(lock_pkg::DISP_PASS);
        check_flag("unlocked", unlocked, 1'b1);
        press_key(lock_pkg::KEY_RESET);
        check_flag("unlocked", unlocked, 1'b0);
    endtask

    task automatic test_invalid_patterns();
        wait_cycles(OK_LEN + FAIL_LEN);  // let every tone die out
        check_flag("buzzer", buzzer, 1'b0);
        press_word(16'h00C0);  // keys 1 and 2 together
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
        if (buzz_rise != 0) begin
            stop_on_error("buzzer sounded for a two-key pattern");
        end
        press_word(16'h0002);  // unused line 1
        check_display(lock_pkg::DISP_BLANK);
        check_tries(exp_tries);
        if (buzz_rise != 0) begin
            stop_on_error("buzzer sounded for an unused keypad line");
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        stop_on_error("timeout, the tests did not finish in time");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        onehot    = '0;
        exp_tries = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        test_reset_state();
        test_digit_entry();
        test_correct_code();
        test_wrong_code();
        test_lockout();
        test_invalid_patterns();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- logic/keypad_lock.sv
`timescale 1ns/1ps

module keypad_lock #(
    parameter logic [lock_pkg::DISP_W-1:0] PASSCODE = 12'h246,
    parameter int CLICK_HALF     = 50000,
    parameter int CLICK_LEN      = 10000000,
    parameter int OK_HALF        = 25000,
    parameter int OK_LEN         = 30000000,
    parameter int FAIL_HALF      = 100000,
    parameter int FAIL_LEN       = 15000000,
    parameter int FAIL_GAP_START = 5000000,
    parameter int FAIL_GAP_END   = 10000000
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [15:0]                   onehot,
    output logic [lock_pkg::DISP_W-1:0]   display,
    output logic [lock_pkg::TRIES_W-1:0]  tries,
    output logic                          unlocked,
    output logic                          locked_out,
    output logic                          buzzer
);

    logic                       key_valid;
    logic [lock_pkg::KEY_W-1:0] key_code;
    logic                       click_start;
    logic                       success_start;
    logic                       fail_start;
    logic                       click_active;
    logic                       click_tone;
    logic                       success_active;
    logic                       success_tone;
    logic                       fail_active;
    logic                       fail_tone;

    key_decoder u_key_decoder (
        .clk       (clk),
        .arst_n    (arst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    code_entry #(
        .PASSCODE (PASSCODE)
    ) u_code_entry (
        .clk           (clk),
        .arst_n        (arst_n),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .display       (display),
        .tries         (tries),
        .unlocked      (unlocked),
        .locked_out    (locked_out),
        .click_start   (click_start),
        .success_start (success_start),
        .fail_start    (fail_start)
    );

    // short click per digit
    tone_gen #(
        .HALF_PERIOD (CLICK_HALF),
        .DURATION    (CLICK_LEN),
        .GAP_START   (0),
        .GAP_END     (0)
    ) u_click_tone (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (click_start),
        .active (click_active),
        .tone   (click_tone)
    );

    tone_gen #(
        .HALF_PERIOD (OK_HALF),
        .DURATION    (OK_LEN),
        .GAP_START   (0),
        .GAP_END     (0)
    ) u_success_tone (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (success_start),
        .active (success_active),
        .tone   (success_tone)
    );

    // slow tone broken by a silent stretch
    tone_gen #(
        .HALF_PERIOD (FAIL_HALF),
        .DURATION    (FAIL_LEN),
        .GAP_START   (FAIL_GAP_START),
        .GAP_END     (FAIL_GAP_END)
    ) u_fail_tone (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (fail_start),
        .active (fail_active),
        .tone   (fail_tone)
    );

    tone_arbiter u_tone_arbiter (
        .clk            (clk),
        .arst_n         (arst_n),
        .click_active   (click_active),
        .click_tone     (click_tone),
        .success_active (success_active),
        .success_tone   (success_tone),
        .fail_active    (fail_active),
        .fail_tone      (fail_tone),
        .buzzer         (buzzer)
    );

endmodule

//--- logic/tone_arbiter.sv
`timescale 1ns/1ps

module tone_arbiter (
    input  logic clk,
    input  logic arst_n,
    input  logic click_active,
    input  logic click_tone,
    input  logic success_active,
    input  logic success_tone,
    input  logic fail_active,
    input  logic fail_tone,
    output logic buzzer
);

    logic buzzer_nxt;

    // fixed priority, fail over success over click
    always_comb begin
        if (fail_active) begin
            buzzer_nxt = fail_tone;
        end else if (success_active) begin
            buzzer_nxt = success_tone;
        end else if (click_active) begin
            buzzer_nxt = click_tone;
        end else begin
            buzzer_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buzzer <= 1'b0;
        end else begin
            buzzer <= buzzer_nxt;  // glitch-free pin
        end
    end

    // pin goes quiet one cycle after every generator stops
    a_silent_after_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(click_active || success_active || fail_active) |=> !buzzer
    );

endmodule

//--- logic/tone_gen.sv
`timescale 1ns/1ps

module tone_gen #(
    parameter int HALF_PERIOD = 50000,
    parameter int DURATION    = 10000000,
    parameter int GAP_START   = 0,
    parameter int GAP_END     = 0
) (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic active,
    output logic tone
);

    localparam int DUR_W  = $clog2(DURATION + 1);
    localparam int HALF_W = $clog2(HALF_PERIOD + 1);

    logic              run;
    logic              phase;      // square wave level
    logic [DUR_W-1:0]  dur_cnt;    // cycle index within the sound
    logic [HALF_W-1:0] half_cnt;   // cycles into current half period

    logic              cur_phase;
    logic [DUR_W-1:0]  cur_dur;
    logic [HALF_W-1:0] cur_half;
    logic              dur_done;
    logic              half_done;
    logic              in_gap;

    // start counts as cycle 0, so the tone is up in the start cycle itself
    assign active    = start | run;
    assign cur_phase = start ? 1'b1 : phase;
    assign cur_dur   = start ? '0 : dur_cnt;
    assign cur_half  = start ? '0 : half_cnt;

    assign dur_done  = cur_dur == DUR_W'(DURATION - 1);
    assign half_done = cur_half == HALF_W'(HALF_PERIOD - 1);
    assign in_gap    = (GAP_END > GAP_START) &&
                       (cur_dur >= DUR_W'(GAP_START)) && (cur_dur < DUR_W'(GAP_END));

    assign tone = cur_phase && !in_gap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run      <= 1'b0;
            phase    <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (dur_done) begin
                run      <= 1'b0;
                phase    <= 1'b0;  // silent once done
                dur_cnt  <= '0;
                half_cnt <= '0;
            end else begin
                run     <= 1'b1;
                dur_cnt <= cur_dur + 1'b1;
                if (half_done) begin
                    half_cnt <= '0;
                    phase    <= ~cur_phase;
                end else begin
                    half_cnt <= cur_half + 1'b1;
                    phase    <= cur_phase;
                end
            end
        end
    end

    // idle generator must leave its wave low
    a_quiet_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        !active |-> !tone
    );

endmodule

//--- logic/code_entry.sv
`timescale 1ns/1ps

module code_entry #(
    parameter logic [lock_pkg::DISP_W-1:0] PASSCODE = 12'h246
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          key_valid,
    input  logic [lock_pkg::KEY_W-1:0]    key_code,
    output logic [lock_pkg::DISP_W-1:0]   display,
    output logic [lock_pkg::TRIES_W-1:0]  tries,
    output logic                          unlocked,
    output logic                          locked_out,
    output logic                          click_start,
    output logic                          success_start,
    output logic                          fail_start
);

    localparam int CNT_W = $clog2(lock_pkg::NUM_DIGITS + 1);

    logic [CNT_W-1:0]             digit_cnt;  // digits currently shown
    logic [lock_pkg::TRIES_W-1:0] tries_inc;
    logic                         is_digit;
    logic                         accepting;
    logic                         full;

    assign tries_inc = tries + 1'b1;
    assign is_digit  = key_code < lock_pkg::KEY_ENTER;  // codes 0..9
    assign accepting = !locked_out && !unlocked;
    assign full      = digit_cnt == CNT_W'(lock_pkg::NUM_DIGITS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            display       <= lock_pkg::DISP_BLANK;
            digit_cnt     <= '0;
            tries         <= '0;
            unlocked      <= 1'b0;
            locked_out    <= 1'b0;
            click_start   <= 1'b0;
            success_start <= 1'b0;
            fail_start    <= 1'b0;
        end else begin
            click_start   <= 1'b0;  // one-cycle pulses
            success_start <= 1'b0;
            fail_start    <= 1'b0;
            if (key_valid) begin
                if (is_digit) begin
                    if (accepting) begin
                        click_start <= 1'b1;
                        if (!full) begin
                            display   <= {display[lock_pkg::DISP_W-lock_pkg::KEY_W-1:0],
                                          key_code};
                            digit_cnt <= digit_cnt + 1'b1;
                        end
                    end
                end else if (key_code == lock_pkg::KEY_ENTER) begin
                    if (accepting && full) begin
                        if (display == PASSCODE) begin
                            display       <= lock_pkg::DISP_PASS;
                            unlocked      <= 1'b1;
                            success_start <= 1'b1;
                        end else begin
                            digit_cnt  <= '0;
                            tries      <= tries_inc;
                            fail_start <= 1'b1;
                            if (tries_inc == lock_pkg::MAX_TRIES) begin
                                display    <= lock_pkg::DISP_LOCKOUT;
                                locked_out <= 1'b1;
                            end else begin
                                display <= lock_pkg::DISP_BLANK;
                            end
                        end
                    end
                end else if (key_code == lock_pkg::KEY_CLEAR) begin
                    display   <= lock_pkg::DISP_BLANK;  // keeps unlock and lockout
                    digit_cnt <= '0;
                end else if (key_code == lock_pkg::KEY_RESET) begin
                    display    <= lock_pkg::DISP_BLANK;
                    digit_cnt  <= '0;
                    tries      <= '0;
                    unlocked   <= 1'b0;
                    locked_out <= 1'b0;
                end
            end
        end
    end

    // lockout stops counting at the limit
    a_tries_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        tries <= lock_pkg::MAX_TRIES
    );

    // the buzzer sees at most one request per cycle
    a_one_start: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({click_start, success_start, fail_start})
    );

endmodule

//--- logic/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [15:0]                onehot,
    output logic                       key_valid,
    output logic [lock_pkg::KEY_W-1:0] key_code
);

    logic [15:0]                prev_onehot;  // last cycle's keypad word
    logic                       pattern_ok;
    logic [lock_pkg::KEY_W-1:0] code_dec;

    // keypad line map, lines 1 2 4 unused
    always_comb begin
        pattern_ok = 1'b1;
        code_dec   = '0;
        case (onehot)
            16'h0001: code_dec = lock_pkg::KEY_ENTER;
            16'h0008: code_dec = 4'd0;
            16'h0020: code_dec = 4'd3;
            16'h0040: code_dec = 4'd2;
            16'h0080: code_dec = 4'd1;
            16'h0100: code_dec = lock_pkg::KEY_RESET;
            16'h0200: code_dec = 4'd6;
            16'h0400: code_dec = 4'd5;
            16'h0800: code_dec = 4'd4;
            16'h1000: code_dec = lock_pkg::KEY_CLEAR;
            16'h2000: code_dec = 4'd9;
            16'h4000: code_dec = 4'd8;
            16'h8000: code_dec = 4'd7;
            default:  pattern_ok = 1'b0;  // zero, multi-hot or unused line
        endcase
    end

    // a press is a new valid word, so a repeated digit still counts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_onehot <= '0;
            key_valid   <= 1'b0;
            key_code    <= '0;
        end else begin
            prev_onehot <= onehot;
            key_valid   <= pattern_ok && (onehot != prev_onehot);
            if (pattern_ok) begin
                key_code <= code_dec;  // held between presses
            end
        end
    end

    // holding a key must not repeat the strobe
    a_single_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        (key_valid && $stable(onehot)) |=> !key_valid
    );

endmodule

//--- logic/lock_pkg.sv
package lock_pkg;

    // key codes, digits 0 to 9 are their own codes
    localparam int KEY_W = 4;
    localparam logic [KEY_W-1:0] KEY_ENTER = 4'd10;
    localparam logic [KEY_W-1:0] KEY_CLEAR = 4'd11;
    localparam logic [KEY_W-1:0] KEY_RESET = 4'd12;

    // display word, one nibble per digit
    localparam int NUM_DIGITS = 3;
    localparam int DISP_W = NUM_DIGITS * KEY_W;

    localparam logic [KEY_W-1:0] BLANK_NIBBLE = 4'hF;  // dark digit

    localparam logic [DISP_W-1:0] DISP_BLANK = {NUM_DIGITS{BLANK_NIBBLE}};

    // glyphs A, S, S on the segment driver
    localparam logic [DISP_W-1:0] DISP_PASS = 12'hBCC;

    localparam logic [DISP_W-1:0] DISP_LOCKOUT = 12'h000;  // all zeros when locked

    // wrong attempt counting
    localparam int TRIES_W = 3;
    localparam logic [TRIES_W-1:0] MAX_TRIES = 3'd6;

endpackage
